// ==== Makefile ====
# Verilator flow for the LVDS receiver.

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f list.f --top-module lvds_rx_top

sim:
	verilator --binary --timing --assert -f list.f --top-module tb_lvds_rx -o tb_lvds_rx
	./obj_dir/tb_lvds_rx | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== list.f ====
+incdir+logic
logic/rx_types_pkg.sv
logic/rx_apb_pkg.sv
logic/lvds_deser.sv
logic/lane_aligner.sv
logic/rx_apb_regs.sv
logic/lvds_rx_top.sv
tb/tb_lvds_rx.sv

// ==== logic/lane_aligner.sv ====
`include "rx_config.svh"

module lane_aligner import rx_types_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     train_en,
   input  logic     lane_reset,
   input  rx_word_t pattern,
   input  rx_word_t word,
   input  logic     word_valid,
   output logic     bitslip,
   output logic     locked
);

   localparam int MATCH_W = $clog2(`RX_LOCK_COUNT + 1);
   localparam int SLIP_W  = $clog2(`RX_MAX_SLIPS + 1);

   align_state_t       state;
   logic [MATCH_W-1:0] match_cnt;
   logic [SLIP_W-1:0]  slip_cnt;
   logic               restart;

   // training off or a lane reset drops the lane back to idle.
   assign restart = reset || lane_reset || !train_en;

   always_ff @(posedge clk) begin
      if (restart) begin
         state     <= IDLE;
         match_cnt <= '0;
         slip_cnt  <= '0;
         bitslip   <= 1'b0;
         locked    <= 1'b0;
      end else begin
         bitslip <= 1'b0;
         case (state)
            IDLE: begin
               match_cnt <= '0;
               slip_cnt  <= '0;
               state     <= CHECK;
            end
            CHECK: begin
               if (word_valid) begin
                  if (word == pattern) begin
                     if (match_cnt == MATCH_W'(`RX_LOCK_COUNT - 1)) begin
                        state  <= LOCKED;
                        locked <= 1'b1;
                     end else begin
                        match_cnt <= match_cnt + 1'b1;
                     end
                  end else begin
                     // move the boundary one bit and start counting again.
                     match_cnt <= '0;
                     bitslip   <= 1'b1;
                     state     <= SLIP;
                     if (slip_cnt == SLIP_W'(`RX_MAX_SLIPS - 1)) begin
                        slip_cnt <= '0;
                     end else begin
                        slip_cnt <= slip_cnt + 1'b1;
                     end
                  end
               end
            end
            SLIP: begin
               state <= SETTLE;
            end
            SETTLE: begin
               // this word straddles the slip.
               if (word_valid) begin
                  state <= CHECK;
               end
            end
            LOCKED: begin
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   a_slip_pulse : assert property (
      @(posedge clk) disable iff (reset)
      bitslip |=> !bitslip
   );

   a_lock_state : assert property (
      @(posedge clk) disable iff (reset)
      locked |-> state == LOCKED
   );

endmodule

// ==== logic/lvds_deser.sv ====
`include "rx_config.svh"

module lvds_deser import rx_types_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     serial,
   input  logic     bitslip,
   output rx_word_t word,
   output logic     word_valid
);

   localparam int CNT_W = $clog2(`RX_WORD_BITS);

   logic [CNT_W-1:0]         bit_cnt;
   logic [`RX_WORD_BITS-2:0] shift;
   logic                     wrap;

   // the tenth bit of a word is on the line.
   // a slip holds the counter, so the boundary moves one bit later.
   assign wrap = (bit_cnt == CNT_W'(`RX_WORD_BITS - 1)) && !bitslip;

   // ########################################
   // bit counter and word strobe.
   // ########################################

   always_ff @(posedge clk) begin
      if (reset) begin
         bit_cnt    <= '0;
         word_valid <= 1'b0;
      end else begin
         word_valid <= wrap;
         if (!bitslip) begin
            if (wrap) begin
               bit_cnt <= '0;
            end else begin
               bit_cnt <= bit_cnt + 1'b1;
            end
         end
      end
   end

   // ########################################
   // shift register and parallel word.
   // ########################################

   // bits arrive LSB first, so new bits enter at the top.
   always_ff @(posedge clk) begin
      shift <= {serial, shift[`RX_WORD_BITS-2:1]};
      if (wrap) begin
         word <= {serial, shift};
      end
   end

   // a word takes at least ten bit times.
   a_valid_spacing : assert property (
      @(posedge clk) disable iff (reset)
      word_valid |=> !word_valid
   );

endmodule

// ==== logic/lvds_rx_top.sv ====
`include "rx_config.svh"

module lvds_rx_top import rx_types_pkg::*, rx_apb_pkg::*; (
   input  logic                 clk,
   input  logic                 reset,
   input  logic [`RX_LANES-1:0] rx_serial,
   input  apb_req_t             apb_req,
   output apb_rsp_t             apb_rsp,
   output rx_bundle_t           rx_out,
   output logic                 rx_locked
);

   rx_word_t [`RX_LANES-1:0] lane_word;
   logic [`RX_LANES-1:0]     lane_valid;
   logic [`RX_LANES-1:0]     lane_slip;
   logic [`RX_LANES-1:0]     lane_locked;
   logic [`RX_LANES-1:0]     lane_reset;
   logic                     train_en;
   rx_word_t                 pattern;

   // ########################################
   // per-lane deserializer and aligner.
   // ########################################

   for (genvar i = 0; i < `RX_LANES; i++) begin : g_lane
      lvds_deser lvds_deser_inst (
         .clk        (clk),
         .reset      (reset),
         .serial     (rx_serial[i]),
         .bitslip    (lane_slip[i]),
         .word       (lane_word[i]),
         .word_valid (lane_valid[i])
      );

      lane_aligner lane_aligner_inst (
         .clk        (clk),
         .reset      (reset),
         .train_en   (train_en),
         .lane_reset (lane_reset[i]),
         .pattern    (pattern),
         .word       (lane_word[i]),
         .word_valid (lane_valid[i]),
         .bitslip    (lane_slip[i]),
         .locked     (lane_locked[i])
      );
   end

   // lanes slip independently, lane 0 stands in for the strobe.
   assign rx_out.word  = lane_word;
   assign rx_out.valid = lane_valid[0];
   assign rx_locked    = &lane_locked;

   // ########################################
   // configuration registers.
   // ########################################

   rx_apb_regs rx_apb_regs_inst (
      .clk        (clk),
      .reset      (reset),
      .apb_req    (apb_req),
      .apb_rsp    (apb_rsp),
      .locked     (lane_locked),
      .words      (rx_out),
      .train_en   (train_en),
      .pattern    (pattern),
      .lane_reset (lane_reset)
   );

endmodule

// ==== logic/rx_apb_pkg.sv ====
package rx_apb_pkg;

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [7:0]  paddr;
      logic [31:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   // register map, byte addresses.
   typedef enum logic [7:0] {
      CTRL        = 8'h00,
      PATTERN     = 8'h04,
      LOCK_STATUS = 8'h08,
      LANE_RESET  = 8'h0C,
      WORD_SEL    = 8'h10,
      WORD_DATA   = 8'h14
   } rx_reg_addr_t;

endpackage

// ==== logic/rx_apb_regs.sv ====
`include "rx_config.svh"

module rx_apb_regs import rx_types_pkg::*, rx_apb_pkg::*; (
   input  logic                 clk,
   input  logic                 reset,
   input  apb_req_t             apb_req,
   output apb_rsp_t             apb_rsp,
   input  logic [`RX_LANES-1:0] locked,
   input  rx_bundle_t           words,
   output logic                 train_en,
   output rx_word_t             pattern,
   output logic [`RX_LANES-1:0] lane_reset
);

   localparam int       LANE_W        = $clog2(`RX_LANES);
   localparam rx_word_t PATTERN_RESET = 10'h17C;

   rx_reg_addr_t addr;
   logic         access;
   logic         wr_en;
   logic         addr_hit;
   logic [31:0]  rd_data;
   logic [7:0]   word_sel;
   rx_word_t     sel_word;

   assign addr   = rx_reg_addr_t'(apb_req.paddr);
   assign access = apb_req.psel && apb_req.penable;
   assign wr_en  = access && apb_req.pwrite;

   // ########################################
   // word snapshot.
   // ########################################

   always_comb begin
      sel_word = '0;
      if (word_sel < `RX_LANES) begin
         sel_word = words.word[word_sel[LANE_W-1:0]];
      end
   end

   // ########################################
   // read decode.
   // ########################################

   // lanes above 31 do not fit the 32-bit status and reset registers.
   always_comb begin
      addr_hit = 1'b1;
      rd_data  = '0;
      case (addr)
         CTRL:        rd_data = 32'(train_en);
         PATTERN:     rd_data = 32'(pattern);
         LOCK_STATUS: rd_data = 32'(locked);
         LANE_RESET:  rd_data = '0;
         WORD_SEL:    rd_data = 32'(word_sel);
         WORD_DATA:   rd_data = 32'(sel_word);
         default:     addr_hit = 1'b0;
      endcase
   end

   assign apb_rsp.prdata  = rd_data;
   assign apb_rsp.pready  = 1'b1;
   assign apb_rsp.pslverr = access && !addr_hit;

   // ########################################
   // write side.
   // ########################################

   always_ff @(posedge clk) begin
      if (reset) begin
         train_en   <= 1'b0;
         pattern    <= PATTERN_RESET;
         word_sel   <= '0;
         lane_reset <= '0;
      end else begin
         lane_reset <= '0;
         if (wr_en) begin
            case (addr)
               CTRL:       train_en   <= apb_req.pwdata[0];
               PATTERN:    pattern    <= rx_word_t'(apb_req.pwdata);
               LANE_RESET: lane_reset <= `RX_LANES'(apb_req.pwdata);
               WORD_SEL:   word_sel   <= apb_req.pwdata[7:0];
               // read-only and unmapped addresses.
               default: ;
            endcase
         end
      end
   end

   a_penable_psel : assert property (
      @(posedge clk) disable iff (reset)
      apb_req.penable |-> apb_req.psel
   );

endmodule

// ==== logic/rx_config.svh ====
`ifndef RX_CONFIG_SVH
`define RX_CONFIG_SVH

// ########################################
// receiver geometry.
// ########################################

// number of serial lanes.
`define RX_LANES 8

// deserialization factor, bits per lane word.
`define RX_WORD_BITS 10

// ########################################
// alignment tuning.
// ########################################

// consecutive pattern matches before a lane reports lock.
`define RX_LOCK_COUNT 4

// slips after which the search restarts its count.
`define RX_MAX_SLIPS 10

`endif

// ==== logic/rx_types_pkg.sv ====
`include "rx_config.svh"

package rx_types_pkg;

   // one deserialized lane word, first received bit in bit 0.
   typedef logic [`RX_WORD_BITS-1:0] rx_word_t;

   // words of all lanes plus the lane 0 strobe.
   typedef struct packed {
      rx_word_t [`RX_LANES-1:0] word;
      logic                     valid;
   } rx_bundle_t;

   // per-lane word alignment states.
   typedef enum logic [2:0] {
      IDLE   = 3'd0,
      CHECK  = 3'd1,
      SLIP   = 3'd2,
      SETTLE = 3'd3,
      LOCKED = 3'd4
   } align_state_t;

endpackage

// ==== tb/tb_lvds_rx.sv ====
`include "rx_config.svh"

module tb_lvds_rx import rx_types_pkg::*, rx_apb_pkg::*;;

   // one stimulus case.
   typedef struct packed {
      logic [3:0] phase_base;
      logic [3:0] phase_step;
      rx_word_t   pattern;
      logic [7:0] payload_words;
      logic [7:0] reset_lane;
   } case_t;

   localparam int NUM_CASES = 3;
   localparam logic [31:0] ALL_LOCKED = 32'({`RX_LANES{1'b1}});

   // lane phase is (base + step * lane) mod 10.
   // base, step, pattern, payload words, lane to reset.
   localparam case_t CASES [NUM_CASES] = '{
      '{4'd0, 4'd1, 10'h17C, 8'd6, 8'd3},
      '{4'd7, 4'd3, 10'h283, 8'd9, 8'd0},
      '{4'd4, 4'd7, 10'h1E6, 8'd5, 8'd6}
   };

   logic                 clk = 1'b0;
   logic                 reset;
   logic [`RX_LANES-1:0] rx_serial = '0;
   apb_req_t             apb_req;
   apb_rsp_t             apb_rsp;
   rx_bundle_t           rx_out;
   logic                 rx_locked;

   case_t                cur_row;
   logic                 drv_load;
   logic                 payload_go;
   int                   cycle;
   bit [`RX_LANES-1:0]   active;
   int                   tx_bit [`RX_LANES];
   rx_word_t             tx_word [`RX_LANES];
   int                   sent [`RX_LANES];
   int                   chk_idx [`RX_LANES];
   rx_word_t             exp_q [`RX_LANES][$];
   int                   due_q [`RX_LANES][$];

   always #5 clk = ~clk;

   lvds_rx_top lvds_rx_top_inst (
      .clk       (clk),
      .reset     (reset),
      .rx_serial (rx_serial),
      .apb_req   (apb_req),
      .apb_rsp   (apb_rsp),
      .rx_out    (rx_out),
      .rx_locked (rx_locked)
   );

   // ########################################
   // failure reporting and helpers.
   // ########################################

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("ERR t=%0t %s expected=0x%0h actual=0x%0h", $time, name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
   endtask

   task automatic timeout_abort(input string what);
      $display("timeout at t=%0t: %s", $time, what);
      $display("SIMULATION FAILED");
      $fatal(1, "wait timed out");
   endtask

   function automatic int lane_phase(input case_t c, input int lane);
      return (int'(c.phase_base) + int'(c.phase_step) * lane) % `RX_WORD_BITS;
   endfunction

   function automatic bit payload_checked(input int words);
      for (int l = 0; l < `RX_LANES; l++) begin
         if (sent[l] < words || chk_idx[l] != due_q[l].size()) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   // ########################################
   // serial lane driver.
   // ########################################

   // words go out LSB first on each lane's own grid.
   always @(posedge clk) begin
      cycle <= cycle + 1;
      for (int l = 0; l < `RX_LANES; l++) begin
         if (drv_load) begin
            tx_bit[l]  = (`RX_WORD_BITS - lane_phase(cur_row, l)) % `RX_WORD_BITS;
            tx_word[l] = cur_row.pattern;
            sent[l]    = 0;
            active[l]  = 1'b1;
         end else if (active[l] && tx_bit[l] == 0) begin
            if (payload_go && sent[l] < int'(cur_row.payload_words)) begin
               tx_word[l] = rx_word_t'($urandom);
               exp_q[l].push_back(tx_word[l]);
               // the DUT shows the word one cycle after its tenth bit.
               due_q[l].push_back(cycle + `RX_WORD_BITS + 1);
               sent[l]++;
            end else begin
               tx_word[l] = cur_row.pattern;
            end
         end
         if (active[l]) begin
            rx_serial[l] <= tx_word[l][tx_bit[l]];
            tx_bit[l] = (tx_bit[l] + 1) % `RX_WORD_BITS;
         end
      end
   end

   // payload words are compared at each lane's own boundary.
   always @(negedge clk) begin
      for (int l = 0; l < `RX_LANES; l++) begin
         if (chk_idx[l] < due_q[l].size() && due_q[l][chk_idx[l]] == cycle) begin
            assert (rx_out.word[l] == exp_q[l][chk_idx[l]])
               else report_mismatch($sformatf("rx_out.word[%0d]", l),
                                    32'(exp_q[l][chk_idx[l]]), 32'(rx_out.word[l]));
            if (l == 0) begin
               assert (rx_out.valid) else report_mismatch("rx_out.valid", 32'd1, 32'd0);
            end
            chk_idx[l]++;
         end
      end
   end

   // ########################################
   // APB access tasks.
   // ########################################

   task automatic apb_access(input logic write, input logic [7:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
      int n;
      @(posedge clk);
      apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
      @(posedge clk);
      apb_req.penable <= 1'b1;
      @(negedge clk);
      for (n = 0; n < 16 && !apb_rsp.pready; n++) begin
         @(negedge clk);
      end
      assert (apb_rsp.pready) else timeout_abort("pready did not rise in the access cycle");
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge clk);
      apb_req <= '0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
      logic [31:0] rdata;
      logic        err;
      apb_access(1'b1, addr, wdata, rdata, err);
      assert (!err) else report_mismatch("apb_rsp.pslverr", 32'd0, 32'(err));
   endtask

   task automatic read_expect(input logic [7:0] addr, input logic [31:0] expected,
                              input string name);
      logic [31:0] rdata;
      logic        err;
      apb_access(1'b0, addr, '0, rdata, err);
      assert (!err) else report_mismatch("apb_rsp.pslverr", 32'd0, 32'(err));
      assert (rdata == expected) else report_mismatch(name, expected, rdata);
   endtask

   // ########################################
   // waits and the per-case sequence.
   // ########################################

   task automatic wait_locked(input string what);
      int n;
      @(negedge clk);
      for (n = 0; n < 40 * `RX_WORD_BITS && !rx_locked; n++) begin
         @(negedge clk);
      end
      assert (rx_locked) else timeout_abort(what);
   endtask

   task automatic wait_payload(input int words);
      int n;
      @(negedge clk);
      for (n = 0; n < (words + 3) * `RX_WORD_BITS && !payload_checked(words); n++) begin
         @(negedge clk);
      end
      assert (payload_checked(words)) else timeout_abort("payload words were not all received");
   endtask

   task automatic run_case(input case_t c);
      logic [31:0] rdata;
      logic        err;
      apb_write(CTRL, 32'd0);
      @(posedge clk);
      payload_go <= 1'b0;
      cur_row    <= c;
      drv_load   <= 1'b1;
      @(posedge clk);
      drv_load   <= 1'b0;
      apb_write(PATTERN, 32'(c.pattern));
      read_expect(PATTERN, 32'(c.pattern), "PATTERN");
      // the lanes carry the new stream before training starts.
      repeat (2 * `RX_WORD_BITS) @(posedge clk);
      apb_write(CTRL, 32'd1);
      wait_locked("rx_locked did not rise within 40 word times");
      read_expect(LOCK_STATUS, ALL_LOCKED, "LOCK_STATUS");

      @(posedge clk);
      payload_go <= 1'b1;
      wait_payload(int'(c.payload_words));

      // one more word time so every lane holds a pattern word again.
      repeat (`RX_WORD_BITS + 1) @(posedge clk);
      apb_write(WORD_SEL, 32'(c.reset_lane));
      read_expect(WORD_DATA, 32'(c.pattern), "WORD_DATA");
      apb_write(WORD_SEL, 32'(`RX_LANES));
      read_expect(WORD_DATA, 32'd0, "WORD_DATA");

      apb_write(LANE_RESET, 32'd1 << c.reset_lane);
      read_expect(LOCK_STATUS, ALL_LOCKED & ~(32'd1 << c.reset_lane), "LOCK_STATUS");
      wait_locked("lane did not lock again after its lane reset");
      read_expect(LOCK_STATUS, ALL_LOCKED, "LOCK_STATUS");

      apb_access(1'b1, 8'h20, 32'hFFFF_FFFF, rdata, err);
      assert (err) else report_mismatch("apb_rsp.pslverr", 32'd1, 32'(err));
      apb_access(1'b0, 8'h18, 32'd0, rdata, err);
      assert (err) else report_mismatch("apb_rsp.pslverr", 32'd1, 32'(err));
      apb_write(LOCK_STATUS, 32'd0);
      read_expect(LOCK_STATUS, ALL_LOCKED, "LOCK_STATUS");
   endtask

   initial begin
      void'($urandom(32'h1820_7863));
      reset      = 1'b1;
      apb_req    = '0;
      drv_load   = 1'b0;
      payload_go = 1'b0;
      cur_row    = CASES[0];
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      assert (!rx_locked) else report_mismatch("rx_locked", 32'd0, 32'(rx_locked));
      assert (!rx_out.valid) else report_mismatch("rx_out.valid", 32'd0, 32'(rx_out.valid));
      read_expect(CTRL, 32'd0, "CTRL");
      read_expect(PATTERN, 32'h17C, "PATTERN");
      for (int r = 0; r < NUM_CASES; r++) begin
         run_case(CASES[r]);
      end
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule
